/* rtl/ls_axi_defines.svh */
// memory depth and response delay macros for the axi sram slave
`ifndef LS_AXI_DEFINES_SVH
`define LS_AXI_DEFINES_SVH

// slave memory size in 32-bit words
// also sets the index width taken from the byte address
`define LS_MEM_WORDS 256

// cycles from ar handshake to rvalid (at least 1)
`define LS_RD_DELAY 2

// cycles from holding both aw and w beats to bvalid (at least 1)
`define LS_WR_DELAY 1

// counter width for either delay
`define LS_DLY_W 4

`endif

/* rtl/ls_axi_pkg.sv */
// funct3 encodings, axi beat size enum and the two-way data word union
`default_nettype none

package ls_axi_pkg;

    // risc-v load/store funct3
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } ls_fn3_e;

    // stores reuse the low two bits of the signed loads
    localparam ls_fn3_e SB = LB;
    localparam ls_fn3_e SH = LH;
    localparam ls_fn3_e SW = LW;

    // axi arsize and awsize where bytes = 2**size
    typedef enum logic [2:0] {
        SIZE_1B = 3'b000,
        SIZE_2B = 3'b001,
        SIZE_4B = 3'b010
    } axi_size_e;

    // one bus word seen as byte lanes or as halfword lanes
    typedef union packed {
        logic [3:0][7:0]  b; // b[0] is bits 7:0
        logic [1:0][15:0] h; // h[1] is bits 31:16
    } data_word_u;

endpackage

`default_nettype wire

/* rtl/ls_request_decode.sv */
// request decode from funct3 and address offset to axi size, byte strobes and store data
`timescale 1ns/100ps
`default_nettype none

module ls_request_decode import ls_axi_pkg::*; (
    input  ls_fn3_e     fn3,
    input  logic [1:0]  addr_low,
    input  logic [31:0] data_in,
    output axi_size_e   size,
    output logic [3:0]  be,
    output logic [31:0] wdata
);

    data_word_u rep; // store data copied to every lane

    // fn3[1:0] is the log2 of the access width for both loads and stores
    assign size = axi_size_e'({1'b0, fn3[1:0]});

    always_comb begin
        case (size)
            SIZE_1B: be = 4'b0001 << addr_low; // one lane
            SIZE_2B: be = addr_low[1] ? 4'b1100 : 4'b0011;
            default: be = 4'b1111;
        endcase
    end

    // replicate so the strobes alone pick the lane
    always_comb begin
        case (size)
            SIZE_1B: rep.b = {4{data_in[7:0]}};
            SIZE_2B: rep.h = {2{data_in[15:0]}};
            default: rep   = data_in;
        endcase
    end

    assign wdata = rep;

    // misaligned accesses are not trapped and would corrupt lanes
    always_comb begin
        if (size == SIZE_2B) begin
            assert final (!addr_low[0])
            else $error("halfword access at odd address");
        end
        if (size == SIZE_4B) begin
            assert final (addr_low == 2'b00)
            else $error("word access not word aligned");
        end
    end

endmodule

`default_nettype wire

/* rtl/axi_master.sv */
// load/store sub-unit issuing single-beat axi4 reads and writes
`timescale 1ns/100ps
`default_nettype none

module axi_master import ls_axi_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // sub-unit side
    input  logic        new_request,
    input  logic        load,
    input  logic        store,
    input  logic [31:0] addr,
    input  axi_size_e   size,
    input  logic [3:0]  be,
    input  logic [31:0] wdata,
    input  logic        ack,
    output logic        ready,
    output logic        data_valid,
    output logic [31:0] data_out,
    // axi side
    input  logic        arready,
    input  logic        awready,
    input  logic        wready,
    input  logic        rvalid,
    input  logic [31:0] rdata,
    input  logic        bvalid,
    output logic [31:0] araddr,
    output axi_size_e   arsize,
    output logic [7:0]  arlen,
    output logic        arvalid,
    output logic [31:0] awaddr,
    output axi_size_e   awsize,
    output logic [7:0]  awlen,
    output logic        awvalid,
    output logic [31:0] wdata_o,
    output logic [3:0]  wstrb,
    output logic        wvalid,
    output logic        wlast,
    output logic        rready,
    output logic        bready
);

    assign arlen  = 8'd0; // single beat only
    assign awlen  = 8'd0;
    assign rready = 1'b1; // never stall the slave
    assign bready = 1'b1;
    assign wlast  = wvalid;

    // request fields held for the access
    always_ff @(posedge clk) begin
        if (new_request) begin
            araddr  <= addr;
            awaddr  <= addr;
            arsize  <= size;
            awsize  <= size;
            wdata_o <= wdata;
            wstrb   <= be;
        end
    end

    // one access in flight so ready stays low until it ends
    always_ff @(posedge clk) begin
        if (rst)
            ready <= 1'b1;
        else if (new_request)
            ready <= 1'b0;
        else if (ack | bvalid) // load ends on ack and store on bresp
            ready <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst)
            data_valid <= 1'b0;
        else if (rvalid & rready)
            data_valid <= 1'b1;
        else if (ack)
            data_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rvalid & rready)
            data_out <= rdata; // held until the next load
    end

    // channel valids set on request and cleared on handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            if (new_request & load)
                arvalid <= 1'b1;
            else if (arready)
                arvalid <= 1'b0;
            if (new_request & store) begin
                awvalid <= 1'b1;
                wvalid  <= 1'b1;
            end else begin
                if (awready)
                    awvalid <= 1'b0;
                if (wready)
                    wvalid <= 1'b0; // aw and w may finish on different cycles
            end
        end
    end

    // the driver honours ready and never overlaps requests
    a_req_while_busy: assert property (@(posedge clk) disable iff (rst)
        new_request |-> ready);
    a_one_kind: assert property (@(posedge clk) disable iff (rst)
        new_request |-> !(load && store));
    a_one_channel: assert property (@(posedge clk) disable iff (rst)
        !(arvalid && (awvalid || wvalid)));

endmodule

`default_nettype wire

/* rtl/load_align.sv */
// load data alignment with lane select and sign or zero extension of the returned word
`timescale 1ns/100ps
`default_nettype none

module load_align import ls_axi_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        new_request,
    input  logic        load,
    input  ls_fn3_e     fn3,
    input  logic [1:0]  addr_low,
    input  logic [31:0] rdata_word,
    output logic [31:0] data_out
);

    ls_fn3_e    fn3_q;  // funct3 of the load in flight
    logic [1:0] off_q;  // byte offset of the load in flight
    data_word_u word;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    // request inputs are gone by the time rdata returns
    always_ff @(posedge clk) begin
        if (rst) begin
            fn3_q <= LW;
            off_q <= 2'b00;
        end else if (new_request & load) begin
            fn3_q <= fn3;
            off_q <= addr_low;
        end
    end

    assign word   = rdata_word;
    assign lane_b = word.b[off_q];
    assign lane_h = word.h[off_q[1]]; // bit 0 is zero for halfwords

    always_comb begin
        case (fn3_q)
            LB:      data_out = {{24{lane_b[7]}}, lane_b};
            LBU:     data_out = {24'd0, lane_b};
            LH:      data_out = {{16{lane_h[15]}}, lane_h};
            LHU:     data_out = {16'd0, lane_h};
            default: data_out = word; // lw
        endcase
    end

endmodule

`default_nettype wire

/* rtl/axi_sram_slave.sv */
// single-beat axi4 slave over a word memory with strobed writes and delayed responses
`timescale 1ns/100ps
`default_nettype none
`include "ls_axi_defines.svh"

module axi_sram_slave import ls_axi_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] araddr,
    input  axi_size_e   arsize,
    input  logic [7:0]  arlen,
    input  logic        arvalid,
    input  logic [31:0] awaddr,
    input  axi_size_e   awsize,
    input  logic [7:0]  awlen,
    input  logic        awvalid,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    input  logic        wlast,
    input  logic        rready,
    input  logic        bready,
    output logic        arready,
    output logic        awready,
    output logic        wready,
    output logic        rvalid,
    output logic [31:0] rdata,
    output logic        bvalid
);

    localparam int IDX_W = $clog2(`LS_MEM_WORDS);
    localparam logic [`LS_DLY_W-1:0] RD_LOAD = `LS_DLY_W'(`LS_RD_DELAY - 1);
    localparam logic [`LS_DLY_W-1:0] WR_LOAD = `LS_DLY_W'(`LS_WR_DELAY - 1);

    logic [31:0] mem [`LS_MEM_WORDS];

    logic                rd_busy;
    logic [`LS_DLY_W-1:0] rd_cnt;
    logic [IDX_W-1:0]    rd_idx;
    logic                aw_have, w_have; // beats held for the pending write
    logic [`LS_DLY_W-1:0] wr_cnt;
    logic [IDX_W-1:0]    wr_idx;
    logic [31:0]         wr_data;
    logic [3:0]          wr_strb;

    assign arready = !rd_busy;
    assign awready = !aw_have;
    assign wready  = !w_have;
    assign rvalid  = rd_busy && (rd_cnt == '0);
    assign rdata   = mem[rd_idx];
    assign bvalid  = aw_have && w_have && (wr_cnt == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_busy <= 1'b0;
            rd_cnt  <= '0;
            rd_idx  <= '0;
        end else if (arvalid && arready) begin
            rd_busy <= 1'b1;
            rd_cnt  <= RD_LOAD;
            rd_idx  <= araddr[IDX_W+1:2]; // word index
        end else if (rvalid && rready) begin
            rd_busy <= 1'b0;
        end else if (rd_busy && rd_cnt != '0) begin
            rd_cnt <= rd_cnt - 1'b1;
        end
    end

    // aw and w in either order with the delay counted once both are held
    always_ff @(posedge clk) begin
        if (rst) begin
            aw_have <= 1'b0;
            w_have  <= 1'b0;
            wr_cnt  <= '0;
            for (int i = 0; i < `LS_MEM_WORDS; i++)
                mem[i] <= 32'd0;
        end else begin
            if (awvalid && awready) begin
                aw_have <= 1'b1;
                wr_idx  <= awaddr[IDX_W+1:2];
            end
            if (wvalid && wready) begin
                w_have  <= 1'b1;
                wr_data <= wdata;
                wr_strb <= wstrb;
            end
            if ((awvalid && awready) || (wvalid && wready))
                wr_cnt <= WR_LOAD; // restart on the later beat
            else if (aw_have && w_have && wr_cnt != '0)
                wr_cnt <= wr_cnt - 1'b1;
            if (bvalid && bready) begin
                aw_have <= 1'b0;
                w_have  <= 1'b0;
                for (int i = 0; i < 4; i++)
                    if (wr_strb[i])
                        mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
            end
        end
    end

    a_ar_single: assert property (@(posedge clk) disable iff (rst)
        arvalid && arready |-> arlen == 8'd0 && arsize <= SIZE_4B);
    a_aw_single: assert property (@(posedge clk) disable iff (rst)
        awvalid && awready |-> awlen == 8'd0 && awsize <= SIZE_4B);
    a_w_last: assert property (@(posedge clk) disable iff (rst)
        wvalid && wready |-> wlast);

endmodule

`default_nettype wire

/* rtl/ls_axi_top.sv */
// load/store subsystem top with request decode, axi master, load align and sram slave
`timescale 1ns/100ps
`default_nettype none

module ls_axi_top import ls_axi_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        new_request,
    input  logic        load,
    input  logic        store,
    input  ls_fn3_e     fn3,
    input  logic [31:0] addr,
    input  logic [31:0] data_in,
    input  logic        ack,
    output logic        ready,
    output logic        data_valid,
    output logic [31:0] data_out
);

    axi_size_e   size;
    logic [3:0]  be;
    logic [31:0] st_wdata;   // replicated store data
    logic [31:0] rdata_word; // captured rdata before alignment

    // axi wires
    logic [31:0] araddr, awaddr, wdata, rdata;
    axi_size_e   arsize, awsize;
    logic [7:0]  arlen, awlen;
    logic [3:0]  wstrb;
    logic        arvalid, arready, awvalid, awready;
    logic        wvalid, wready, wlast;
    logic        rvalid, rready, bvalid, bready;

    ls_request_decode ls_request_decode_i (
        .fn3(fn3), .addr_low(addr[1:0]), .data_in(data_in),
        .size(size), .be(be), .wdata(st_wdata)
    );

    axi_master axi_master_i (
        .clk(clk), .rst(rst),
        .new_request(new_request), .load(load), .store(store), .addr(addr),
        .size(size), .be(be), .wdata(st_wdata), .ack(ack),
        .ready(ready), .data_valid(data_valid), .data_out(rdata_word),
        .arready(arready), .awready(awready), .wready(wready),
        .rvalid(rvalid), .rdata(rdata), .bvalid(bvalid),
        .araddr(araddr), .arsize(arsize), .arlen(arlen), .arvalid(arvalid),
        .awaddr(awaddr), .awsize(awsize), .awlen(awlen), .awvalid(awvalid),
        .wdata_o(wdata), .wstrb(wstrb), .wvalid(wvalid), .wlast(wlast),
        .rready(rready), .bready(bready)
    );

    load_align load_align_i (
        .clk(clk), .rst(rst),
        .new_request(new_request), .load(load), .fn3(fn3), .addr_low(addr[1:0]),
        .rdata_word(rdata_word), .data_out(data_out)
    );

    axi_sram_slave axi_sram_slave_i (
        .clk(clk), .rst(rst),
        .araddr(araddr), .arsize(arsize), .arlen(arlen), .arvalid(arvalid),
        .awaddr(awaddr), .awsize(awsize), .awlen(awlen), .awvalid(awvalid),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wlast(wlast),
        .rready(rready), .bready(bready),
        .arready(arready), .awready(awready), .wready(wready),
        .rvalid(rvalid), .rdata(rdata), .bvalid(bvalid)
    );

endmodule

`default_nettype wire

/* dv/ls_axi_tb.sv */
// testbench with clock, reset, stimulus table, lcg ack gaps, checks and timeout
`timescale 1ns/100ps
`default_nettype none

module ls_axi_tb import ls_axi_pkg::*; ();

    localparam bit OP_LD = 1'b0;
    localparam bit OP_ST = 1'b1;

    logic        clk;
    logic        rst;
    logic        new_request, load, store, ack;
    ls_fn3_e     fn3;
    logic [31:0] addr, data_in;
    logic        ready, data_valid;
    logic [31:0] data_out;

    // stimulus table with one column per queue
    bit          tbl_op[$];
    ls_fn3_e     tbl_fn3[$];
    logic [31:0] tbl_addr[$];
    logic [31:0] tbl_data[$];
    logic [31:0] tbl_exp[$];

    logic [31:0] lcg_state = 32'h9b9a_9284;
    int          gap;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    ls_axi_top ls_axi_top_i (
        .clk(clk), .rst(rst),
        .new_request(new_request), .load(load), .store(store),
        .fn3(fn3), .addr(addr), .data_in(data_in), .ack(ack),
        .ready(ready), .data_valid(data_valid), .data_out(data_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic add_entry(input bit op, input ls_fn3_e f, input logic [31:0] a,
                             input logic [31:0] d, input logic [31:0] e);
        tbl_op.push_back(op);
        tbl_fn3.push_back(f);
        tbl_addr.push_back(a);
        tbl_data.push_back(d);
        tbl_exp.push_back(e);
    endtask

    // inputs change and outputs are read 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    initial begin
        rst         = 1'b1;
        new_request = 1'b0;
        load        = 1'b0;
        store       = 1'b0;
        ack         = 1'b0;
        fn3         = LW;
        addr        = 32'd0;
        data_in     = 32'd0;

        // expected values assume a zeroed memory and the stores above them
        add_entry(OP_LD, LW,  32'h040, 32'h0, 32'h0000_0000); // never written
        add_entry(OP_LD, LHU, 32'h042, 32'h0, 32'h0000_0000);
        add_entry(OP_ST, SW,  32'h000, 32'h1234_5678, 32'h0);
        add_entry(OP_ST, SW,  32'h004, 32'hdead_beef, 32'h0);
        add_entry(OP_ST, SW,  32'h3fc, 32'hcafe_f00d, 32'h0); // last word
        add_entry(OP_LD, LW,  32'h000, 32'h0, 32'h1234_5678);
        add_entry(OP_LD, LW,  32'h004, 32'h0, 32'hdead_beef);
        add_entry(OP_LD, LW,  32'h3fc, 32'h0, 32'hcafe_f00d);
        add_entry(OP_ST, SB,  32'h010, 32'ha5a5_a511, 32'h0); // upper bits ignored
        add_entry(OP_ST, SB,  32'h011, 32'h0000_0022, 32'h0);
        add_entry(OP_ST, SB,  32'h012, 32'h1234_5633, 32'h0);
        add_entry(OP_ST, SB,  32'h013, 32'hffff_ff44, 32'h0);
        add_entry(OP_LD, LW,  32'h010, 32'h0, 32'h4433_2211); // lane order
        add_entry(OP_ST, SH,  32'h020, 32'h0000_c0de, 32'h0);
        add_entry(OP_ST, SH,  32'h022, 32'h7777_1234, 32'h0);
        add_entry(OP_LD, LW,  32'h020, 32'h0, 32'h1234_c0de);
        add_entry(OP_LD, LB,  32'h004, 32'h0, 32'hffff_ffef); // sign bit set
        add_entry(OP_LD, LBU, 32'h004, 32'h0, 32'h0000_00ef);
        add_entry(OP_LD, LB,  32'h007, 32'h0, 32'hffff_ffde);
        add_entry(OP_LD, LBU, 32'h006, 32'h0, 32'h0000_00ad);
        add_entry(OP_LD, LB,  32'h010, 32'h0, 32'h0000_0011); // positive byte
        add_entry(OP_LD, LH,  32'h004, 32'h0, 32'hffff_beef);
        add_entry(OP_LD, LHU, 32'h004, 32'h0, 32'h0000_beef);
        add_entry(OP_LD, LH,  32'h006, 32'h0, 32'hffff_dead);
        add_entry(OP_LD, LHU, 32'h006, 32'h0, 32'h0000_dead);
        add_entry(OP_LD, LH,  32'h020, 32'h0, 32'hffff_c0de);
        add_entry(OP_LD, LH,  32'h022, 32'h0, 32'h0000_1234);
        add_entry(OP_ST, SW,  32'h004, 32'h0bad_f00d, 32'h0);
        add_entry(OP_LD, LW,  32'h004, 32'h0, 32'h0bad_f00d); // right after store
        add_entry(OP_ST, SB,  32'h005, 32'h0000_0099, 32'h0);
        add_entry(OP_LD, LBU, 32'h005, 32'h0, 32'h0000_0099);
        add_entry(OP_LD, LW,  32'h004, 32'h0, 32'h0bad_990d);
        add_entry(OP_LD, LW,  32'h000, 32'h0, 32'h1234_5678); // neighbour untouched
        cycle_limit = tbl_op.size() * 40 + 8;

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        check("ready", ready, 1'b1);
        check("data_valid", data_valid, 1'b0);

        for (int i = 0; i < tbl_op.size(); i++) begin
            while (ready !== 1'b1)
                next_cycle();
            new_request = 1'b1;
            load        = (tbl_op[i] == OP_LD);
            store       = (tbl_op[i] == OP_ST);
            fn3         = tbl_fn3[i];
            addr        = tbl_addr[i];
            data_in     = tbl_data[i];
            next_cycle();
            new_request = 1'b0;
            load        = 1'b0;
            store       = 1'b0;
            check("ready", ready, 1'b0); // busy from the next cycle

            if (tbl_op[i] == OP_LD) begin
                while (data_valid !== 1'b1)
                    next_cycle();
                check("data_out", data_out, tbl_exp[i]);
                lcg_state = lcg_next(lcg_state);
                gap       = lcg_state[29:28]; // 0 to 3 idle cycles
                repeat (gap) begin
                    next_cycle();
                    check("data_valid", data_valid, 1'b1);
                    check("data_out", data_out, tbl_exp[i]);
                    check("ready", ready, 1'b0);
                end
                check("ready", ready, 1'b0);
                ack = 1'b1;
                next_cycle();
                ack = 1'b0;
                check("ready", ready, 1'b1); // back the cycle after ack
                check("data_valid", data_valid, 1'b0);
            end else begin
                while (ready !== 1'b1)
                    next_cycle(); // store ends on bvalid
                check("data_valid", data_valid, 1'b0);
            end
        end

        next_cycle();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+rtl
rtl/ls_axi_pkg.sv
rtl/ls_request_decode.sv
rtl/axi_master.sv
rtl/load_align.sv
rtl/axi_sram_slave.sv
rtl/ls_axi_top.sv
dv/ls_axi_tb.sv
